// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert
TOP      = tb_alu_exec
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Finished with errors" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD) $(LOG)

// File: files.f
rtl/alu_pkg.sv
rtl/cla_group4.sv
rtl/cla_adder32.sv
rtl/barrel_shifter32.sv
rtl/mag_comp32.sv
rtl/alu_exec.sv
tests/tb_alu_exec.sv

// File: rtl/alu_exec.sv
// registered integer execute unit
module alu_exec (
   input  logic             CLK,
   input  logic             rst_n,
   input  logic             in_valid,
   input  alu_pkg::alu_op_e op,
   input  alu_pkg::word_t   a,
   input  alu_pkg::word_t   b,
   input  alu_pkg::shamt_t  shamt,
   output logic             out_valid,
   output alu_pkg::word_t   result,
   output logic             cf,
   output logic             af,
   output logic             of,
   output logic             zf,
   output logic             sf,
   output logic             gt,
   output logic             lt,
   output logic             eq
);

   logic                 is_sub;
   logic                 is_shift;
   logic                 is_cmp;
   alu_pkg::word_t       add_b;
   alu_pkg::word_t       sum;
   logic                 add_cout;
   logic                 add_aux;
   logic                 add_ovf;
   alu_pkg::shift_kind_e sh_kind;
   alu_pkg::word_t       sh_out;
   logic                 sh_last;
   logic                 cmp_gt;
   logic                 cmp_lt;
   logic                 cmp_eq;
   alu_pkg::word_t       res_d;
   logic                 cf_d;

   // opcode decode
   assign is_cmp   = (op == alu_pkg::OP_CMP);
   assign is_sub   = (op == alu_pkg::OP_SUB) | is_cmp;
   assign is_shift = (op == alu_pkg::OP_SAL) | (op == alu_pkg::OP_SAR) |
                     (op == alu_pkg::OP_SHR);

   // subtract as a + ~b + 1
   assign add_b = is_sub ? ~b : b;

   always_comb begin
      case (op)
         alu_pkg::OP_SAL: sh_kind = alu_pkg::SH_LEFT;
         alu_pkg::OP_SAR: sh_kind = alu_pkg::SH_ARITH_RIGHT;
         default:         sh_kind = alu_pkg::SH_LOGIC_RIGHT;
      endcase
   end

   cla_adder32 u_add (
      .a         (a),
      .b         (add_b),
      .cin       (is_sub),
      .sum       (sum),
      .cout      (add_cout),
      .aux_carry (add_aux),
      .overflow  (add_ovf)
   );

   barrel_shifter32 u_shift (
      .din      (a),
      .shamt    (shamt),
      .kind     (sh_kind),
      .dout     (sh_out),
      .last_out (sh_last)
   );

   mag_comp32 u_cmp (
      .a  (a),
      .b  (b),
      .gt (cmp_gt),
      .lt (cmp_lt),
      .eq (cmp_eq)
   );

   // result select, borrow is the inverted carry
   assign res_d = is_shift ? sh_out : sum;
   assign cf_d  = is_shift ? sh_last : (add_cout ^ is_sub);

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         result    <= '0;
         cf        <= 1'b0;
         af        <= 1'b0;
         of        <= 1'b0;
         zf        <= 1'b0;
         sf        <= 1'b0;
         gt        <= 1'b0;
         lt        <= 1'b0;
         eq        <= 1'b0;
      end else begin
         out_valid <= in_valid;
         // outputs hold between strobes
         if (in_valid) begin
            result <= res_d;
            cf     <= cf_d;
            af     <= ~is_shift & (add_aux ^ is_sub);
            of     <= ~is_shift & add_ovf;
            zf     <= (res_d == '0);
            sf     <= res_d[alu_pkg::DATA_W-1];
            gt     <= is_cmp & cmp_gt;
            lt     <= is_cmp & cmp_lt;
            eq     <= is_cmp & cmp_eq;
         end
      end
   end

   a_valid_known: assert property (@(posedge CLK) disable iff (!rst_n)
      !$isunknown(out_valid));

   a_op_legal: assert property (@(posedge CLK) disable iff (!rst_n)
      in_valid |-> op inside {alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_SAL,
                              alu_pkg::OP_SAR, alu_pkg::OP_SHR, alu_pkg::OP_CMP});

   // a compare strobe yields exactly one relation on the next cycle
   a_cmp_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
      (in_valid && is_cmp) |=> (out_valid && $onehot({gt, lt, eq})));

endmodule

// File: rtl/alu_pkg.sv
// execute unit shared definitions
package alu_pkg;

   // datapath geometry
   localparam int DATA_W     = 32;
   localparam int GROUP_W    = 4;
   localparam int NUM_GROUPS = DATA_W / GROUP_W;
   localparam int SHAMT_W    = 5;

   typedef logic [DATA_W-1:0]  word_t;
   typedef logic [SHAMT_W-1:0] shamt_t;

   // operations accepted by the execute unit
   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_SAL = 3'd2,
      OP_SAR = 3'd3,
      OP_SHR = 3'd4,
      OP_CMP = 3'd5
   } alu_op_e;

   // shifter direction and fill
   typedef enum logic [1:0] {
      SH_LEFT        = 2'd0,
      SH_ARITH_RIGHT = 2'd1,
      SH_LOGIC_RIGHT = 2'd2
   } shift_kind_e;

endpackage

// File: rtl/barrel_shifter32.sv
// five stage logarithmic barrel shifter
module barrel_shifter32 (
   input  alu_pkg::word_t      din,
   input  alu_pkg::shamt_t     shamt,
   input  alu_pkg::shift_kind_e kind,
   output alu_pkg::word_t      dout,
   output logic                last_out
);

   localparam int W = alu_pkg::DATA_W;

   logic fill;

   // sign fill only for arithmetic right shifts
   assign fill = (kind == alu_pkg::SH_ARITH_RIGHT) & din[W-1];

   // stages of 16, 8, 4, 2 and 1 tracking the bit that leaves the word
   always_comb begin
      alu_pkg::word_t cur;
      logic           last;
      int             s;
      cur  = din;
      last = 1'b0;
      for (int k = alu_pkg::SHAMT_W - 1; k >= 0; k--) begin
         s = 1 << k;
         if (shamt[k]) begin
            if (kind == alu_pkg::SH_LEFT) begin
               last = cur[W - s];
               cur  = cur << s;
            end else begin
               last = cur[s - 1];
               cur  = (cur >> s) | ({W{fill}} & ~({W{1'b1}} >> s));
            end
         end
      end
      dout     = cur;
      last_out = last;
   end

endmodule

// File: rtl/cla_adder32.sv
// two level carry lookahead adder
module cla_adder32 (
   input  alu_pkg::word_t a,
   input  alu_pkg::word_t b,
   input  logic           cin,
   output alu_pkg::word_t sum,
   output logic           cout,
   output logic           aux_carry,
   output logic           overflow
);

   localparam int GW = alu_pkg::GROUP_W;
   localparam int NG = alu_pkg::NUM_GROUPS;

   logic [NG-1:0] grp_p;
   logic [NG-1:0] grp_g;
   logic [NG-1:0] grp_c3;
   logic [NG-1:0] grp_cout;
   // carry into each group, last entry is the adder carry out
   logic [NG:0]   grp_cin;

   genvar gi;
   generate
      for (gi = 0; gi < NG; gi++) begin : g_grp
         cla_group4 u_grp (
            .a    (a[gi*GW +: GW]),
            .b    (b[gi*GW +: GW]),
            .cin  (grp_cin[gi]),
            .sum  (sum[gi*GW +: GW]),
            .gp   (grp_p[gi]),
            .gg   (grp_g[gi]),
            .c3   (grp_c3[gi]),
            .cout (grp_cout[gi])
         );
      end
   endgenerate

   // second level
   // each group carry is a flat sum of products over the lower groups,
   // walking down from the nearest group while the propagate chain holds
   always_comb begin
      logic chain_p;
      logic carry;
      grp_cin[0] = cin;
      for (int i = 1; i <= NG; i++) begin
         chain_p = 1'b1;
         carry   = 1'b0;
         for (int j = i - 1; j >= 0; j--) begin
            carry   = carry | (chain_p & grp_g[j]);
            chain_p = chain_p & grp_p[j];
         end
         grp_cin[i] = carry | (chain_p & cin);
      end
   end

   assign cout = grp_cin[NG];

   // nibble carry out of bit 3
   assign aux_carry = grp_cout[0];

   // signed overflow, carry into the msb differs from carry out of it
   assign overflow = grp_c3[NG-1] ^ grp_cout[NG-1];

endmodule

// File: rtl/cla_group4.sv
// four bit carry lookahead group
module cla_group4 (
   input  logic [3:0] a,
   input  logic [3:0] b,
   input  logic       cin,
   output logic [3:0] sum,
   output logic       gp,
   output logic       gg,
   output logic       c3,
   output logic       cout
);

   logic [3:0] p;
   logic [3:0] g;
   logic       c1;
   logic       c2;

   // per bit propagate and generate
   assign p = a ^ b;
   assign g = a & b;

   // carries into bits 1..3, each from the group inputs only
   assign c1 = g[0] | (p[0] & cin);

   assign c2 = g[1]
             | (p[1] & g[0])
             | (p[1] & p[0] & cin);

   assign c3 = g[2]
             | (p[2] & g[1])
             | (p[2] & p[1] & g[0])
             | (p[2] & p[1] & p[0] & cin);

   // group terms for the next lookahead level
   assign gp = &p;

   assign gg = g[3]
             | (p[3] & g[2])
             | (p[3] & p[2] & g[1])
             | (p[3] & p[2] & p[1] & g[0]);

   assign cout = gg | (gp & cin);

   assign sum = p ^ {c3, c2, c1, cin};

endmodule

// File: rtl/mag_comp32.sv
// bytewise unsigned magnitude comparator
module mag_comp32 (
   input  alu_pkg::word_t a,
   input  alu_pkg::word_t b,
   output logic           gt,
   output logic           lt,
   output logic           eq
);

   logic [3:0] byte_gt;
   logic [3:0] byte_lt;
   logic [3:0] byte_eq;

   genvar bi;
   generate
      for (bi = 0; bi < 4; bi++) begin : g_byte
         assign byte_gt[bi] = a[bi*8 +: 8] > b[bi*8 +: 8];
         assign byte_lt[bi] = a[bi*8 +: 8] < b[bi*8 +: 8];
         assign byte_eq[bi] = a[bi*8 +: 8] == b[bi*8 +: 8];
      end
   endgenerate

   // most significant unequal byte decides
   assign gt = byte_gt[3]
             | (byte_eq[3] & byte_gt[2])
             | (byte_eq[3] & byte_eq[2] & byte_gt[1])
             | (byte_eq[3] & byte_eq[2] & byte_eq[1] & byte_gt[0]);

   assign lt = byte_lt[3]
             | (byte_eq[3] & byte_lt[2])
             | (byte_eq[3] & byte_eq[2] & byte_lt[1])
             | (byte_eq[3] & byte_eq[2] & byte_eq[1] & byte_lt[0]);

   assign eq = &byte_eq;

endmodule

// File: tests/tb_alu_exec.sv
// execute unit testbench
module tb_alu_exec;

   // limit well above the roughly 350 cycles the tests take
   localparam int MAX_CYCLES = 2000;

   logic             CLK;
   logic             rst_n;
   logic             in_valid;
   alu_pkg::alu_op_e op;
   alu_pkg::word_t   a;
   alu_pkg::word_t   b;
   alu_pkg::shamt_t  shamt;
   logic             out_valid;
   alu_pkg::word_t   result;
   logic             cf;
   logic             af;
   logic             of;
   logic             zf;
   logic             sf;
   logic             gt;
   logic             lt;
   logic             eq;

   alu_pkg::word_t lfsr;
   string          ctx;
   int             err_count;
   int             err_mark;
   int             pass_tests;
   int             fail_tests;
   int             cycles;

   alu_exec dut0 (
      .CLK (CLK), .rst_n (rst_n), .in_valid (in_valid), .op (op), .a (a), .b (b),
      .shamt (shamt), .out_valid (out_valid), .result (result), .cf (cf), .af (af),
      .of (of), .zf (zf), .sf (sf), .gt (gt), .lt (lt), .eq (eq)
   );

   always #5 CLK = ~CLK;

   always @(posedge CLK) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("run timed out after %0d cycles", cycles);
         $display("Finished with errors");
         $finish;
      end
   end

   // galois lfsr stepped once per bit taken
   function automatic alu_pkg::word_t rand_bits(input int n);
      alu_pkg::word_t v;
      logic           bit_out;
      v = '0;
      for (int i = 0; i < n; i++) begin
         bit_out = lfsr[0];
         lfsr = lfsr >> 1;
         if (bit_out)
            lfsr = lfsr ^ 32'h8020_0003;
         v = {v[30:0], bit_out};
      end
      return v;
   endfunction

   // expected result with flags {cf, af, of, zf, sf} and compare {gt, lt, eq}
   task automatic model_op(input alu_pkg::alu_op_e o, input alu_pkg::word_t x,
                           input alu_pkg::word_t y, input alu_pkg::shamt_t n,
                           output alu_pkg::word_t r, output logic [4:0] fl,
                           output logic [2:0] c);
      logic [32:0] wide;
      logic [4:0]  nib;
      logic        c_f;
      logic        a_f;
      logic        o_f;
      c = 3'b000;
      case (o)
         alu_pkg::OP_ADD: begin
            wide = {1'b0, x} + {1'b0, y};
            nib  = {1'b0, x[3:0]} + {1'b0, y[3:0]};
            r    = wide[31:0];
            c_f  = wide[32];
            a_f  = nib[4];
            o_f  = (x[31] == y[31]) && (r[31] != x[31]);
         end
         alu_pkg::OP_SAL, alu_pkg::OP_SAR, alu_pkg::OP_SHR: begin
            // last bit out lands in the extra position of a 33 bit word
            if (o == alu_pkg::OP_SAL) begin
               wide = {1'b0, x} << n;
               r    = x << n;
               c_f  = wide[32];
            end else begin
               wide = {x, 1'b0} >> n;
               if (o == alu_pkg::OP_SAR)
                  r = $signed(x) >>> n;
               else
                  r = x >> n;
               c_f  = wide[0];
            end
            a_f = 1'b0;
            o_f = 1'b0;
         end
         default: begin
            r   = x - y;
            c_f = x < y;
            a_f = x[3:0] < y[3:0];
            o_f = (x[31] != y[31]) && (r[31] != x[31]);
            if (o == alu_pkg::OP_CMP)
               c = {x > y, x < y, x == y};
         end
      endcase
      fl = {c_f, a_f, o_f, r == '0, r[31]};
   endtask

   task automatic check_word(input string what, input alu_pkg::word_t got,
                             input alu_pkg::word_t exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s %s is %h, expected %h", $time, ctx, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_flags(input logic [4:0] got, input logic [4:0] exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s flags cf af of zf sf are %b, expected %b",
                  $time, ctx, got, exp);
         err_count++;
      end
   endtask

   task automatic check_cmp(input logic [2:0] got, input logic [2:0] exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s gt lt eq are %b, expected %b", $time, ctx, got, exp);
         err_count++;
      end
   endtask

   task automatic check_valid(input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s out_valid is %b, expected %b", $time, ctx, got, exp);
         err_count++;
      end
   endtask

   task automatic expect_outputs(input alu_pkg::word_t r, input logic [4:0] fl,
                                 input logic [2:0] c);
      check_valid(out_valid, 1'b1);
      check_word("result", result, r);
      check_flags({cf, af, of, zf, sf}, fl);
      check_cmp({gt, lt, eq}, c);
   endtask

   task automatic apply_inputs(input alu_pkg::alu_op_e o, input alu_pkg::word_t x,
                               input alu_pkg::word_t y, input alu_pkg::shamt_t n);
      in_valid = 1'b1;
      op       = o;
      a        = x;
      b        = y;
      shamt    = n;
      ctx      = $sformatf("%s a=%h b=%h n=%0d", o.name(), x, y, n);
   endtask

   // one strobe with outputs checked one cycle later
   task automatic issue_op(input alu_pkg::alu_op_e o, input alu_pkg::word_t x,
                           input alu_pkg::word_t y, input alu_pkg::shamt_t n);
      alu_pkg::word_t r;
      logic [4:0]     fl;
      logic [2:0]     c;
      model_op(o, x, y, n, r, fl, c);
      @(posedge CLK);
      #1;
      apply_inputs(o, x, y, n);
      @(posedge CLK);
      #1;
      in_valid = 1'b0;
      expect_outputs(r, fl, c);
   endtask

   task automatic reset_idle();
      ctx = "after reset";
      check_valid(out_valid, 1'b0);
      check_word("result", result, '0);
      check_flags({cf, af, of, zf, sf}, 5'b00000);
      check_cmp({gt, lt, eq}, 3'b000);
   endtask

   task automatic add_corners();
      issue_op(alu_pkg::OP_ADD, 32'hFFFF_FFFF, 32'h1, '0);
      issue_op(alu_pkg::OP_ADD, 32'h7FFF_FFFF, 32'h1, '0);
      issue_op(alu_pkg::OP_ADD, 32'h0000_000F, 32'h1, '0);
      for (int i = 0; i < 20; i++)
         issue_op(alu_pkg::OP_ADD, rand_bits(32), rand_bits(32), '0);
   endtask

   task automatic sub_compare();
      alu_pkg::word_t x;
      alu_pkg::word_t y;
      for (int i = 0; i < 10; i++) begin
         x = rand_bits(32);
         y = rand_bits(32);
         issue_op(alu_pkg::OP_SUB, x, y, '0);
         issue_op(alu_pkg::OP_CMP, x, y, '0);
         issue_op(alu_pkg::OP_CMP, y, x, '0);
      end
      x = rand_bits(32);
      issue_op(alu_pkg::OP_CMP, x, x, '0);
      issue_op(alu_pkg::OP_SUB, x, x, '0);
      issue_op(alu_pkg::OP_SUB, 32'h0, 32'h1, '0);
   endtask

   task automatic shift_sweep(input alu_pkg::alu_op_e o);
      alu_pkg::word_t d;
      for (int i = 0; i < 32; i++) begin
         d     = rand_bits(32);
         // alternate the sign so sar sees both fills
         d[31] = i[0];
         issue_op(o, d, '0, alu_pkg::shamt_t'(i));
      end
   endtask

   task automatic back_to_back();
      alu_pkg::word_t   q_res[$];
      logic [4:0]       q_fl[$];
      logic [2:0]       q_cmp[$];
      alu_pkg::alu_op_e o;
      alu_pkg::word_t   x;
      alu_pkg::word_t   y;
      alu_pkg::shamt_t  n;
      alu_pkg::word_t   r;
      logic [4:0]       fl;
      logic [2:0]       c;
      for (int i = 0; i <= 40; i++) begin
         @(posedge CLK);
         #1;
         if (q_res.size() > 0)
            expect_outputs(q_res.pop_front(), q_fl.pop_front(), q_cmp.pop_front());
         if (i == 40) begin
            in_valid = 1'b0;
         end else begin
            o = alu_pkg::alu_op_e'(3'(rand_bits(3) % 6));
            x = rand_bits(32);
            y = rand_bits(32);
            n = alu_pkg::shamt_t'(rand_bits(5));
            model_op(o, x, y, n, r, fl, c);
            q_res.push_back(r);
            q_fl.push_back(fl);
            q_cmp.push_back(c);
            apply_inputs(o, x, y, n);
         end
      end
      // strobe gap drops out_valid and holds the last result
      @(posedge CLK);
      #1;
      ctx = "after strobe gap";
      check_valid(out_valid, 1'b0);
      check_word("held result", result, r);
      check_flags({cf, af, of, zf, sf}, fl);
      check_cmp({gt, lt, eq}, c);
   endtask

   task automatic report_test(input string name);
      if (err_count == err_mark) begin
         pass_tests++;
         $display("test %s: ok", name);
      end else begin
         fail_tests++;
         $display("test %s: %0d errors", name, err_count - err_mark);
      end
      err_mark = err_count;
   endtask

   initial begin
      CLK        = 1'b0;
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      op         = alu_pkg::OP_ADD;
      a          = '0;
      b          = '0;
      shamt      = '0;
      lfsr       = 32'd96;
      err_count  = 0;
      err_mark   = 0;
      pass_tests = 0;
      fail_tests = 0;
      cycles     = 0;
      repeat (2) @(posedge CLK);
      #1;
      rst_n = 1'b1;
      reset_idle();
      report_test("reset");
      add_corners();
      report_test("add");
      sub_compare();
      report_test("sub_cmp");
      shift_sweep(alu_pkg::OP_SAL);
      shift_sweep(alu_pkg::OP_SAR);
      shift_sweep(alu_pkg::OP_SHR);
      report_test("shift");
      back_to_back();
      report_test("throughput");
      $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
      if (err_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule
